// ==== source/cart_types_pkg.sv ====
package cart_types_pkg;

	// ********************************************************************
	// Cartridge hardware types
	// ********************************************************************

	// Hardware type field of the CRT header, only the mappers kept here
	typedef enum logic [15:0] {
		CART_GENERIC    = 16'd0,	// 8K, 16K and Ultimax
		CART_SIMONS     = 16'd4,
		CART_OCEAN      = 16'd5,	// type 1
		CART_MAGIC_DESK = 16'd19,
		CART_EASYFLASH  = 16'd32
	} cart_id_t;

	// ********************************************************************
	// Bank tables
	// ********************************************************************

	localparam int BANK_W       = 7;	// Up to 128 banks of 8K
	localparam int BANK_SLOTS   = 64;	// Entries per table
	localparam int SLOT_W       = $clog2(BANK_SLOTS);
	localparam int RAW_BANK_LSB = 13;	// 8K granule in the chip packet address

	// Chip packets loaded at or below 8000h start in the ROML window
	localparam logic [15:0] LO_LOAD_LIMIT = 16'h8000;
	// Anything larger spills over into ROMH
	localparam logic [15:0] CHIP_8K       = 16'h2000;

	// Magic Desk bank register width follows the size of the image
	localparam logic [7:0] MD_CNT_16 = 8'd16;
	localparam logic [7:0] MD_CNT_32 = 8'd32;
	localparam logic [7:0] MD_CNT_64 = 8'd64;

endpackage

// ==== source/mem_map_pkg.sv ====
package mem_map_pkg;

	// ********************************************************************
	// Address field widths
	// ********************************************************************

	localparam int SDRAM_AW   = 25;
	localparam int CPU_AW     = 18;	// CPU address as seen by the memory mux
	localparam int PAGE_AW    = 13;	// Offset inside one 8K bank
	localparam int RAM_BANK_W = 3;	// 8 banks of cartridge RAM

	// ********************************************************************
	// SDRAM regions
	// ********************************************************************

	// C64 main memory
	localparam logic [SDRAM_AW-1:0] RAM_BASE = 25'h0000000;
	// Cartridge RAM, 64K at most
	localparam logic [SDRAM_AW-1:0] CRM_BASE = 25'h0040000;
	// CRT chip data, 1M at most
	localparam logic [SDRAM_AW-1:0] CRT_BASE = 25'h0100000;

	// None of the kept types puts ROM or RAM behind IOE
	localparam logic IOE_MAPPED = 1'b0;

endpackage

// ==== source/bank_table.sv ====
`timescale 1ns/100ps

module bank_table (
	input  logic                              clk32,
	input  logic                              reset_n,
	input  logic                              cart_loading,
	input  logic [15:0]                       cart_bank_num,
	input  logic [15:0]                       cart_bank_laddr,
	input  logic [15:0]                       cart_bank_size,
	input  logic [24:0]                       cart_bank_raddr,
	input  logic                              cart_bank_wr,
	input  logic [cart_types_pkg::SLOT_W-1:0] lo_index,
	input  logic [cart_types_pkg::SLOT_W-1:0] hi_index,
	output logic [cart_types_pkg::BANK_W-1:0] lo_bank,
	output logic [cart_types_pkg::BANK_W-1:0] hi_bank,
	output logic [7:0]                        bank_cnt
);
	import cart_types_pkg::*;

	logic [BANK_W-1:0] lo_table [BANK_SLOTS];
	logic [BANK_W-1:0] hi_table [BANK_SLOTS];
	logic              old_loading;
	logic              load_start;
	logic              slot_ok;
	logic [SLOT_W-1:0] slot;
	logic [BANK_W-1:0] raw_bank;

	assign load_start = cart_loading & ~old_loading;
	assign slot_ok    = cart_bank_num < 16'(BANK_SLOTS);	// Higher banks are dropped
	assign slot       = cart_bank_num[SLOT_W-1:0];
	assign raw_bank   = cart_bank_raddr[RAW_BANK_LSB +: BANK_W];

	// Counts chip packets of the current image
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_loading <= 1'b0;
			bank_cnt    <= '0;
		end else begin
			old_loading <= cart_loading;
			if (load_start)
				bank_cnt <= '0;
			if (cart_bank_wr)
				bank_cnt <= bank_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk32) begin
		if (cart_bank_wr && slot_ok) begin
			if (cart_bank_laddr <= LO_LOAD_LIMIT) begin
				lo_table[slot] <= raw_bank;
				if (cart_bank_size > CHIP_8K)	// 16K chip, upper half is ROMH
					hi_table[slot] <= raw_bank + BANK_W'(1);
			end else begin
				hi_table[slot] <= raw_bank;
			end
		end
	end

	assign lo_bank = lo_table[lo_index];
	assign hi_bank = hi_table[hi_index];

	// Chip packets only arrive inside the loader's window
	assert property (@(posedge clk32) disable iff (reset_n) cart_bank_wr |-> cart_loading)
		else $error("bank_table: chip packet while cart_loading is low");

endmodule

// ==== source/io_strobe_decode.sv ====
`timescale 1ns/100ps

module io_strobe_decode (
	input  logic clk32,
	input  logic reset_n,
	input  logic ioe,
	input  logic iof,
	input  logic mem_write,
	output logic stb_ioe,
	output logic stb_iof,
	output logic ioe_wr,
	output logic ioe_rd,
	output logic iof_wr
);

	logic old_ioe;
	logic old_iof;

	// Previous level of the IO select lines
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			old_ioe <= 1'b0;
			old_iof <= 1'b0;
		end else begin
			old_ioe <= ioe;
			old_iof <= iof;
		end
	end

	// First cycle of an access only
	assign stb_ioe = ioe & ~old_ioe;
	assign stb_iof = iof & ~old_iof;

	assign ioe_wr = stb_ioe & mem_write;
	assign ioe_rd = stb_ioe & ~mem_write;
	assign iof_wr = stb_iof & mem_write;	// IOF reads need no event

	// One access gives exactly one IOE event, never repeated on the next cycle
	assert property (@(posedge clk32) disable iff (reset_n)
		(ioe_wr || ioe_rd) |-> (ioe_wr != ioe_rd) ##1 !(ioe_wr || ioe_rd))
		else $error("io_strobe_decode: IOE event not single");

endmodule

// ==== source/bank_control.sv ====
`timescale 1ns/100ps

module bank_control (
	input  logic                                 clk32,
	input  logic                                 reset_n,
	input  cart_types_pkg::cart_id_t             cart_id,
	input  logic [7:0]                           cart_exrom,
	input  logic [7:0]                           cart_game,
	input  logic                                 ioe_wr,
	input  logic                                 ioe_rd,
	input  logic                                 iof_wr,
	input  logic [mem_map_pkg::CPU_AW-1:0]       addr_in,
	input  logic [7:0]                           data_in,
	input  logic [7:0]                           bank_cnt,
	input  logic [cart_types_pkg::BANK_W-1:0]    lo_bank,
	input  logic [cart_types_pkg::BANK_W-1:0]    hi_bank,
	output logic [cart_types_pkg::SLOT_W-1:0]    lo_index,
	output logic [cart_types_pkg::SLOT_W-1:0]    hi_index,
	output logic [cart_types_pkg::BANK_W-1:0]    bank_lo,
	output logic [cart_types_pkg::BANK_W-1:0]    bank_hi,
	output logic [mem_map_pkg::RAM_BANK_W-1:0]   iof_bank,
	output logic                                 iof_ena,
	output logic                                 iof_wr_ena,
	output logic                                 exrom,
	output logic                                 game
);
	import cart_types_pkg::*;

	cart_id_t          old_id;
	logic              init_n;		// Low on the cycle after a clear
	logic              id_change;
	logic              io_strobe;
	logic              ef_select;
	logic [BANK_W-1:0] md_bank;

	assign id_change = (cart_id != old_id);
	assign io_strobe = ioe_wr | ioe_rd | iof_wr;

	// EasyFlash bank write looks up both tables at the written number
	assign ef_select = (cart_id == CART_EASYFLASH) && ioe_wr && !addr_in[1];
	assign lo_index  = ef_select ? data_in[SLOT_W-1:0] : '0;
	assign hi_index  = ef_select ? data_in[SLOT_W-1:0] : '0;

	// Magic Desk register is only as wide as the image needs
	always_comb begin
		if (bank_cnt <= MD_CNT_16)
			md_bank = BANK_W'(data_in[3:0]);
		else if (bank_cnt <= MD_CNT_32)
			md_bank = BANK_W'(data_in[4:0]);
		else if (bank_cnt <= MD_CNT_64)
			md_bank = BANK_W'(data_in[5:0]);
		else
			md_bank = data_in[BANK_W-1:0];
	end

	// ********************************************************************
	// Register machine
	// ********************************************************************

	always_ff @(posedge clk32) begin
		old_id <= cart_id;
		init_n <= 1'b1;

		if (reset_n || id_change) begin
			bank_lo    <= '0;
			bank_hi    <= '0;
			iof_bank   <= '0;
			iof_ena    <= 1'b0;
			iof_wr_ena <= 1'b0;
			exrom      <= 1'b1;	// Cartridge off the bus
			game       <= 1'b1;
			init_n     <= 1'b0;
		end else begin
			// Types with fixed lines
			case (cart_id)
				CART_GENERIC: begin
					exrom   <= cart_exrom[0];
					game    <= cart_game[0];
					bank_lo <= lo_bank;
					bank_hi <= hi_bank;
				end
				CART_OCEAN: begin
					exrom <= 1'b0;
					game  <= 1'b0;
				end
				default: ;
			endcase

			if (!init_n) begin
				// Start state of each type
				case (cart_id)
					CART_SIMONS: begin
						exrom   <= 1'b0;
						game    <= 1'b0;
						bank_lo <= BANK_W'(0);
						bank_hi <= BANK_W'(1);
					end
					CART_MAGIC_DESK: begin
						exrom   <= 1'b0;
						game    <= 1'b1;
						bank_lo <= '0;
					end
					CART_EASYFLASH: begin
						iof_bank   <= '0;
						iof_ena    <= 1'b1;
						iof_wr_ena <= 1'b1;
						exrom      <= 1'b1;	// Boots in Ultimax mode
						game       <= 1'b0;
						bank_lo    <= lo_bank;
						bank_hi    <= hi_bank;
					end
					default: ;
				endcase
			end else if (io_strobe) begin
				case (cart_id)
					CART_SIMONS: begin
						if (ioe_wr)
							game <= 1'b0;	// 16K
						else if (ioe_rd)
							game <= 1'b1;	// 8K
					end
					CART_OCEAN: begin
						if (ioe_wr) begin
							bank_lo <= BANK_W'(data_in[5:0]);
							bank_hi <= BANK_W'(data_in[5:0]);
						end
					end
					CART_MAGIC_DESK: begin
						if (ioe_wr) begin
							bank_lo <= md_bank;
							exrom   <= data_in[7];	// Bit 7 hides the cartridge
						end
					end
					CART_EASYFLASH: begin
						if (ioe_wr) begin
							if (addr_in[1]) begin
								// Control register, boot jumper read as set
								game  <= ~data_in[0] & data_in[2];
								exrom <= ~data_in[1];
							end else begin
								bank_lo <= lo_bank;
								bank_hi <= hi_bank;
							end
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Lines are released on the first cycle out of reset
	assert property (@(posedge clk32) $fell(reset_n) |-> exrom && game)
		else $error("bank_control: EXROM/GAME not released after reset");

endmodule

// ==== source/address_map.sv ====
`timescale 1ns/100ps

module address_map (
	input  logic                                 reset_n,
	input  logic [mem_map_pkg::CPU_AW-1:0]       addr_in,
	input  logic                                 roml,
	input  logic                                 romh,
	input  logic                                 ioe,
	input  logic                                 iof,
	input  logic                                 mem_write,
	input  logic                                 mem_ce,
	input  logic                                 stb_ioe,
	input  logic                                 stb_iof,
	input  logic [cart_types_pkg::BANK_W-1:0]    bank_lo,
	input  logic [cart_types_pkg::BANK_W-1:0]    bank_hi,
	input  logic [mem_map_pkg::RAM_BANK_W-1:0]   iof_bank,
	input  logic                                 iof_ena,
	input  logic                                 iof_wr_ena,
	input  logic                                 exrom,
	input  logic                                 game,
	output logic [mem_map_pkg::SDRAM_AW-1:0]     addr_out,
	output logic                                 mem_write_out,
	output logic                                 mem_ce_out
);
	import mem_map_pkg::*;

	logic                cs_ioe;
	logic                cs_iof;
	logic [SDRAM_AW-1:0] ram_addr;
	logic [SDRAM_AW-1:0] lo_addr;
	logic [SDRAM_AW-1:0] hi_addr;
	logic [SDRAM_AW-1:0] crm_addr;

	// IO areas backed by memory for this access direction
	assign cs_ioe = IOE_MAPPED & ioe;
	assign cs_iof = iof & (mem_write ? iof_wr_ena : iof_ena);

	// IO accesses carry no mem_ce of their own, one extra cycle per access
	assign mem_ce_out = mem_ce | (cs_ioe & stb_ioe) | (cs_iof & stb_iof);

	// Ultimax leaves no RAM under ROML
	assign mem_write_out = mem_write & ~(roml & exrom & ~game);

	// ********************************************************************
	// SDRAM address per region
	// ********************************************************************

	assign ram_addr = RAM_BASE + SDRAM_AW'(addr_in);
	assign lo_addr  = CRT_BASE + SDRAM_AW'({bank_lo, addr_in[PAGE_AW-1:0]});
	assign hi_addr  = CRT_BASE + SDRAM_AW'({bank_hi, addr_in[PAGE_AW-1:0]});
	assign crm_addr = CRM_BASE + SDRAM_AW'({iof_bank, addr_in[PAGE_AW-1:0]});

	// Later regions win
	always_comb begin
		addr_out = ram_addr;
		if (!reset_n) begin
			if (romh && !mem_write)
				addr_out = hi_addr;
			if (roml && !mem_write)
				addr_out = lo_addr;
			if (cs_iof)
				addr_out = crm_addr;	// DFxx into cartridge RAM
		end
	end

endmodule

// ==== source/cartridge.sv ====
`timescale 1ns/100ps

module cartridge (
	input  logic                              clk32,
	input  logic                              reset_n,
	input  logic                              cart_loading,
	input  cart_types_pkg::cart_id_t          cart_id,
	input  logic [7:0]                        cart_exrom,
	input  logic [7:0]                        cart_game,
	input  logic [15:0]                       cart_bank_laddr,
	input  logic [15:0]                       cart_bank_size,
	input  logic [15:0]                       cart_bank_num,
	input  logic [24:0]                       cart_bank_raddr,
	input  logic                              cart_bank_wr,
	output logic                              exrom,
	output logic                              game,
	input  logic                              roml,
	input  logic                              romh,
	input  logic                              ioe,
	input  logic                              iof,
	input  logic                              mem_write,
	input  logic                              mem_ce,
	output logic                              mem_ce_out,
	output logic                              mem_write_out,
	input  logic [mem_map_pkg::CPU_AW-1:0]    addr_in,
	input  logic [7:0]                        data_in,
	output logic [mem_map_pkg::SDRAM_AW-1:0]  addr_out
);
	import cart_types_pkg::*;
	import mem_map_pkg::*;

	logic                  stb_ioe;
	logic                  stb_iof;
	logic                  ioe_wr;
	logic                  ioe_rd;
	logic                  iof_wr;
	logic [SLOT_W-1:0]     lo_index;
	logic [SLOT_W-1:0]     hi_index;
	logic [BANK_W-1:0]     lo_bank;
	logic [BANK_W-1:0]     hi_bank;
	logic [7:0]            bank_cnt;
	logic [BANK_W-1:0]     bank_lo;
	logic [BANK_W-1:0]     bank_hi;
	logic [RAM_BANK_W-1:0] iof_bank;
	logic                  iof_ena;
	logic                  iof_wr_ena;

	io_strobe_decode u_decode (
		.clk32, .reset_n, .ioe, .iof, .mem_write,
		.stb_ioe, .stb_iof, .ioe_wr, .ioe_rd, .iof_wr
	);

	bank_control u_control (
		.clk32, .reset_n, .cart_id, .cart_exrom, .cart_game,
		.ioe_wr, .ioe_rd, .iof_wr, .addr_in, .data_in,
		.bank_cnt, .lo_bank, .hi_bank, .lo_index, .hi_index,
		.bank_lo, .bank_hi, .iof_bank, .iof_ena, .iof_wr_ena, .exrom, .game
	);

	bank_table u_table (
		.clk32, .reset_n, .cart_loading, .cart_bank_num, .cart_bank_laddr,
		.cart_bank_size, .cart_bank_raddr, .cart_bank_wr,
		.lo_index, .hi_index, .lo_bank, .hi_bank, .bank_cnt
	);

	address_map u_map (
		.reset_n, .addr_in, .roml, .romh, .ioe, .iof, .mem_write, .mem_ce,
		.stb_ioe, .stb_iof, .bank_lo, .bank_hi, .iof_bank, .iof_ena, .iof_wr_ena,
		.exrom, .game, .addr_out, .mem_write_out, .mem_ce_out
	);

endmodule

// ==== include/cartridge_model.svh ====
`ifndef CARTRIDGE_MODEL_SVH
`define CARTRIDGE_MODEL_SVH

// Bank number held in a chip packet's SDRAM address
function automatic logic [cart_types_pkg::BANK_W-1:0] model_raw_bank(input logic [24:0] raddr);
	return raddr[cart_types_pkg::RAW_BANK_LSB +: cart_types_pkg::BANK_W];
endfunction

// ROML window starts at 8000h
function automatic bit model_lo_write(input logic [15:0] num, input logic [15:0] laddr);
	return (num < 16'(cart_types_pkg::BANK_SLOTS)) && (laddr <= 16'h8000);
endfunction

function automatic bit model_hi_write(input logic [15:0] num, input logic [15:0] laddr,
		input logic [15:0] size);
	if (num >= 16'(cart_types_pkg::BANK_SLOTS))
		return 1'b0;
	return (laddr > 16'h8000) || (size > 16'h2000);	// 8K chip fits ROML alone
endfunction

// ROMH entry, one bank up when a 16K chip starts in ROML
function automatic logic [cart_types_pkg::BANK_W-1:0] model_hi_value(input logic [15:0] laddr,
		input logic [24:0] raddr);
	if (laddr <= 16'h8000)
		return model_raw_bank(raddr) + 7'd1;
	return model_raw_bank(raddr);
endfunction

function automatic logic [cart_types_pkg::BANK_W-1:0] model_md_bank(input logic [7:0] data,
		input logic [7:0] cnt);
	if (cnt <= 8'd16)
		return {3'b000, data[3:0]};
	if (cnt <= 8'd32)
		return {2'b00, data[4:0]};
	if (cnt <= 8'd64)
		return {1'b0, data[5:0]};
	return data[6:0];
endfunction

// EasyFlash control register at DE02
function automatic logic model_ef_game(input logic [7:0] data);
	return ~data[0] & data[2];
endfunction

function automatic logic model_ef_exrom(input logic [7:0] data);
	return ~data[1];
endfunction

function automatic logic [24:0] model_rom_addr(input logic [6:0] bank, input logic [17:0] addr);
	return mem_map_pkg::CRT_BASE + {5'd0, bank, addr[12:0]};
endfunction

function automatic logic [24:0] model_crm_addr(input logic [2:0] bank, input logic [17:0] addr);
	return mem_map_pkg::CRM_BASE + {9'd0, bank, addr[12:0]};
endfunction

function automatic logic [24:0] model_ram_addr(input logic [17:0] addr);
	return mem_map_pkg::RAM_BASE + {7'd0, addr};
endfunction

function automatic logic model_write_out(input logic mem_write, input logic roml,
		input logic exrom, input logic game);
	if (roml && exrom && !game)
		return 1'b0;	// Ultimax, no RAM under ROML
	return mem_write;
endfunction

`endif

// ==== tb/cartridge_tb.sv ====
`timescale 1ns/100ps

module cartridge_tb;
	import cart_types_pkg::*;
	import mem_map_pkg::*;

	`include "cartridge_model.svh"

	localparam int MAX_CYCLES = 4000;	// Tests take about 200 cycles
	localparam logic [17:0] IO1_REG  = 18'h0DE00;
	localparam logic [17:0] IO1_CTRL = 18'h0DE02;	// EasyFlash control register
	localparam logic [17:0] IO2_BASE = 18'h0DF00;
	localparam logic [17:0] ROML_BASE = 18'h08000;
	localparam logic [17:0] ROMH_BASE = 18'h0A000;

	logic        clk32;
	logic        reset_n;
	logic        cart_loading;
	cart_id_t    cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [15:0] cart_bank_num;
	logic [24:0] cart_bank_raddr;
	logic        cart_bank_wr;
	logic        exrom;
	logic        game;
	logic        roml;
	logic        romh;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	logic        mem_ce;
	logic        mem_ce_out;
	logic        mem_write_out;
	logic [17:0] addr_in;
	logic [7:0]  data_in;
	logic [24:0] addr_out;

	// Model of the bank tables and mapper registers
	logic [6:0] lo_tab [64];
	logic [6:0] hi_tab [64];
	bit         lo_ok [64];
	bit         hi_ok [64];
	logic [7:0] m_cnt;
	logic [6:0] m_lo;
	logic [6:0] m_hi;
	bit         m_lo_ok;
	bit         m_hi_ok;
	logic       m_exrom;
	logic       m_game;
	logic       m_iof_ena;
	logic       m_iof_wr_ena;

	// Expected outputs handed to the compare process
	logic        chk_on;
	bit          chk_addr;
	logic [24:0] exp_addr;
	logic        exp_exrom;
	logic        exp_game;
	logic        exp_wr;
	logic        exp_ce;

	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_base = 0;

	cartridge DUT (.*);

	initial begin
		clk32 = 1'b0;
		forever #2 clk32 = ~clk32;
	end

	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [24:0] got, input logic [24:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk32) begin
		if (chk_on) begin
			if (chk_addr)
				compare("addr_out", addr_out, exp_addr);
			compare("exrom", 25'(exrom), 25'(exp_exrom));
			compare("game", 25'(game), 25'(exp_game));
			compare("mem_write_out", 25'(mem_write_out), 25'(exp_wr));
			compare("mem_ce_out", 25'(mem_ce_out), 25'(exp_ce));
		end
	end

	// **********************************************************************
	// Reference model
	// **********************************************************************

	// RAM first, then ROM reads, then an enabled IOF
	function automatic logic [24:0] expected_addr(input logic rl, input logic rh, input logic f,
			input logic wr, input logic [17:0] a);
		logic [24:0] res;
		res = model_ram_addr(a);
		if (!reset_n) begin
			if (rh && !wr)
				res = model_rom_addr(m_hi, a);
			if (rl && !wr)
				res = model_rom_addr(m_lo, a);
			if (f && (wr ? m_iof_wr_ena : m_iof_ena))
				res = model_crm_addr(3'd0, a);
		end
		return res;
	endfunction

	// ROM bank taken from a slot that was never loaded
	function automatic bit addr_known(input logic rl, input logic rh, input logic f,
			input logic wr);
		if (reset_n || wr || (f && m_iof_ena))
			return 1'b1;
		if (rl)
			return m_lo_ok;
		if (rh)
			return m_hi_ok;
		return 1'b1;
	endfunction

	function automatic logic [17:0] rand_addr(input logic [17:0] base, input int span);
		return base + 18'($urandom_range(0, span - 1));
	endfunction

	// **********************************************************************
	// Stimulus tasks
	// **********************************************************************

	task automatic access(input logic rl, input logic rh, input logic f, input logic wr,
			input logic ce, input logic [17:0] a, input int len);
		int i;
		roml      = rl;
		romh      = rh;
		iof       = f;
		mem_write = wr;
		mem_ce    = ce;
		addr_in   = a;
		exp_addr  = expected_addr(rl, rh, f, wr, a);
		chk_addr  = addr_known(rl, rh, f, wr);
		exp_exrom = m_exrom;
		exp_game  = m_game;
		exp_wr    = model_write_out(wr, rl, m_exrom, m_game);
		for (i = 0; i < len; i++) begin
			exp_ce = ce | (i == 0 && f && (wr ? m_iof_wr_ena : m_iof_ena));	// IOF rise only
			chk_on = 1'b1;
			@(posedge clk32);
			#1;
		end
		chk_on    = 1'b0;
		roml      = 1'b0;
		romh      = 1'b0;
		iof       = 1'b0;
		mem_write = 1'b0;
		mem_ce    = 1'b0;
	endtask

	// New mapping is in place two cycles after the IOE rise
	task automatic io_access(input logic [17:0] a, input logic [7:0] d, input logic wr);
		ioe       = 1'b1;
		mem_write = wr;
		addr_in   = a;
		data_in   = d;
		@(posedge clk32);
		#1;
		ioe       = 1'b0;
		mem_write = 1'b0;
		@(posedge clk32);
		#1;
	endtask

	task automatic load_packet(input logic [15:0] num);
		int kind;
		kind = (num == 16'd0) ? 1 : int'($urandom_range(0, 3));	// Slot 0 always 16K
		cart_bank_num   = num;
		cart_bank_raddr = CRT_BASE + {5'd0, 7'($urandom), 13'd0};
		case (kind)
			0: begin
				cart_bank_laddr = 16'h8000;
				cart_bank_size  = 16'h2000;
			end
			1: begin
				cart_bank_laddr = 16'h8000;
				cart_bank_size  = 16'h4000;
			end
			2: begin
				cart_bank_laddr = 16'hA000;
				cart_bank_size  = 16'h2000;
			end
			default: begin
				cart_bank_laddr = 16'hE000;	// Ultimax image
				cart_bank_size  = 16'h2000;
			end
		endcase
		if (model_lo_write(num, cart_bank_laddr)) begin
			lo_tab[num[5:0]] = model_raw_bank(cart_bank_raddr);
			lo_ok[num[5:0]]  = 1'b1;
		end
		if (model_hi_write(num, cart_bank_laddr, cart_bank_size)) begin
			hi_tab[num[5:0]] = model_hi_value(cart_bank_laddr, cart_bank_raddr);
			hi_ok[num[5:0]]  = 1'b1;
		end
		m_cnt++;
		cart_bank_wr = 1'b1;
		@(posedge clk32);
		#1;
		cart_bank_wr = 1'b0;
	endtask

	task automatic load_image(input int count);
		int i;
		cart_loading = 1'b1;
		m_cnt = 8'd0;
		@(posedge clk32);
		#1;
		for (i = 0; i < count; i++)
			load_packet(16'(i));
		cart_loading = 1'b0;
		@(posedge clk32);
		#1;
	endtask

	// Id change clears the registers, the cycle after is the init cycle
	task automatic select_type(input cart_id_t id);
		cart_id = id;
		repeat (3) @(posedge clk32);
		#1;
		m_lo         = 7'd0;
		m_hi         = 7'd0;
		m_lo_ok      = 1'b1;
		m_hi_ok      = 1'b1;
		m_iof_ena    = 1'b0;
		m_iof_wr_ena = 1'b0;
		m_exrom      = 1'b0;
		m_game       = 1'b0;
		case (id)
			CART_SIMONS:
				m_hi = 7'd1;
			CART_MAGIC_DESK:
				m_game = 1'b1;
			CART_EASYFLASH: begin
				m_iof_ena    = 1'b1;
				m_iof_wr_ena = 1'b1;
				m_exrom      = 1'b1;
				m_lo         = lo_tab[0];
				m_hi         = hi_tab[0];
				m_lo_ok      = lo_ok[0];
				m_hi_ok      = hi_ok[0];
			end
			default: ;
		endcase
	endtask

	task automatic report(input string name);
		if (errors == test_base)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial begin
		logic [7:0] d;
		int idx;
		int n;
		reset_n         = 1'b1;
		cart_loading    = 1'b0;
		cart_id         = CART_GENERIC;
		cart_exrom      = 8'h01;
		cart_game       = 8'h01;
		cart_bank_laddr = 16'h0;
		cart_bank_size  = 16'h0;
		cart_bank_num   = 16'h0;
		cart_bank_raddr = 25'h0;
		cart_bank_wr    = 1'b0;
		roml            = 1'b0;
		romh            = 1'b0;
		ioe             = 1'b0;
		iof             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = 18'h0;
		data_in         = 8'h0;
		chk_on          = 1'b0;
		m_cnt           = 8'd0;
		m_lo            = 7'd0;
		m_hi            = 7'd0;
		m_lo_ok         = 1'b0;
		m_hi_ok         = 1'b0;
		m_exrom         = 1'b1;	// Lines released in reset
		m_game          = 1'b1;
		m_iof_ena       = 1'b0;
		m_iof_wr_ena    = 1'b0;
		void'($urandom(32'heb56));

		// Ten cycles of reset, the last two with ROM accesses
		repeat (8) @(posedge clk32);
		#1;
		access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		access(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, rand_addr(ROMH_BASE, 8192), 1);
		reset_n = 1'b0;
		access(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(18'h00000, 32768), 1);
		cart_game = 8'h00;	// Ultimax
		@(posedge clk32);
		#1;
		m_game = 1'b0;
		access(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		access(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, rand_addr(18'h00000, 32768), 1);
		report("reset and default mapping");

		load_image(16);
		for (n = 0; n < 8; n++) begin
			cart_exrom = 8'($urandom);
			cart_game  = 8'($urandom);
			@(posedge clk32);
			#1;
			m_exrom = cart_exrom[0];
			m_game  = cart_game[0];
			m_lo    = lo_tab[0];
			m_hi    = hi_tab[0];
			m_lo_ok = lo_ok[0];
			m_hi_ok = hi_ok[0];
			access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
			access(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, rand_addr(ROMH_BASE, 8192), 1);
		end
		report("generic bank table");

		select_type(CART_OCEAN);
		for (n = 0; n < 8; n++) begin
			d = 8'($urandom);
			io_access(IO1_REG, d, 1'b1);
			m_lo = {1'b0, d[5:0]};
			m_hi = {1'b0, d[5:0]};
			access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
			access(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, rand_addr(ROMH_BASE, 8192), 1);
		end
		report("ocean bank register");

		load_image(40);
		select_type(CART_MAGIC_DESK);
		for (n = 0; n < 6; n++) begin
			d = 8'($urandom);
			if (n == 0)
				d[6:5] = 2'b11;	// Bit 5 kept and bit 6 dropped for 40 banks
			io_access(IO1_REG, d, 1'b1);
			m_lo    = model_md_bank(d, m_cnt);	// 6 bits for 40 banks
			m_exrom = d[7];
			access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		end
		report("magic desk bank register");

		select_type(CART_EASYFLASH);
		access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		idx = int'($urandom_range(0, 39));
		while (!(lo_ok[idx] && hi_ok[idx]))
			idx = (idx + 1) % 40;	// Slot 0 is always loaded in both tables
		io_access(IO1_REG, {2'($urandom), 6'(idx)}, 1'b1);
		m_lo = lo_tab[idx];
		m_hi = hi_tab[idx];
		access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		access(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, rand_addr(ROMH_BASE, 8192), 1);
		d = 8'($urandom);
		io_access(IO1_CTRL, d, 1'b1);
		m_game  = model_ef_game(d);
		m_exrom = model_ef_exrom(d);
		access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		access(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, rand_addr(IO2_BASE, 256), 2);
		@(posedge clk32);	// IOF low for one cycle, the write is a new access
		#1;
		access(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, rand_addr(IO2_BASE, 256), 1);
		report("easyflash banks and control");

		select_type(CART_SIMONS);
		access(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, rand_addr(ROMH_BASE, 8192), 1);
		io_access(IO1_REG, 8'($urandom), 1'b0);
		m_game = 1'b1;	// 8K mode
		access(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, rand_addr(ROML_BASE, 8192), 1);
		io_access(IO1_REG, 8'($urandom), 1'b1);
		m_game = 1'b0;
		access(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, rand_addr(ROMH_BASE, 8192), 1);
		report("simons basic game line");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
source/cart_types_pkg.sv
source/mem_map_pkg.sv
source/bank_table.sv
source/io_strobe_decode.sv
source/bank_control.sv
source/address_map.sv
source/cartridge.sv
tb/cartridge_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat src.f)) include/cartridge_model.svh

.PHONY: run clean

run: obj_dir/Vcartridge_tb
	obj_dir/Vcartridge_tb > sim.log
	cat sim.log
	! grep -q "Test failed" sim.log

obj_dir/Vcartridge_tb: src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module cartridge_tb \
		--Mdir obj_dir -o Vcartridge_tb

clean:
	rm -rf obj_dir sim.log
